/* lenet_pkg.sv */
`default_nettype none

package lenet_pkg;

    // ########################################################################
    // sizes
    // ########################################################################

    // kernel side
    localparam int KERNEL    = 5;
    localparam int PIX_W     = 8;
    localparam int PROD_W    = 16;
    // five products per row
    localparam int ROW_SUM_W = 19;
    // twenty-five products per window
    localparam int ACC_W     = 21;
    localparam int ACT_SHIFT = 8;
    localparam int ROW_IDX_W = 3;

    // ########################################################################
    // weight address map
    // ########################################################################

    localparam int W_ADDR_W = 5;
    // 0 to 24 are weights, row-major
    localparam logic [W_ADDR_W-1:0] BIAS_ADDR = 5'd25;

    // ########################################################################
    // row types, element 0 in the top bits
    // ########################################################################

    typedef struct packed {
        logic [0:KERNEL-1][PIX_W-1:0] pix;
    } pix_row_t;

    typedef struct packed {
        logic [0:KERNEL-1][PIX_W-1:0] wgt;
    } wgt_row_t;

endpackage

`default_nettype wire

/* lenet_approx_mul.sv */
`default_nettype none

module lenet_approx_mul
    import lenet_pkg::*;
(
    input  logic [PIX_W-1:0]  x,
    input  logic [PIX_W-1:0]  y,
    output logic [PROD_W-1:0] z
);

    // partial product rows, one per bit of x
    logic [PIX_W-1:0] pp [PIX_W];

    // sparse correction words for rows 0 to 5
    logic [12:0] cor1;
    logic [12:0] cor2;
    logic [12:0] cor3;
    logic [12:0] cor4;
    logic [12:0] cor5;
    logic [12:0] cor6;

    logic [PROD_W-1:0] row6;
    logic [PROD_W-1:0] row7;
    logic [PROD_W-1:0] cor_sum;

    assign pp[0] = y & {PIX_W{x[0]}};
    assign pp[1] = y & {PIX_W{x[1]}};
    assign pp[2] = y & {PIX_W{x[2]}};
    assign pp[3] = y & {PIX_W{x[3]}};
    assign pp[4] = y & {PIX_W{x[4]}};
    assign pp[5] = y & {PIX_W{x[5]}};
    assign pp[6] = y & {PIX_W{x[6]}};
    assign pp[7] = y & {PIX_W{x[7]}};

    // ########################################################################
    // compressed lower rows
    // ########################################################################

    always_comb begin
        cor1 = '0;
        cor1[5]  = pp[4][1] & pp[5][0];
        cor1[6]  = pp[2][4] ^ pp[3][3];
        cor1[7]  = pp[4][2] ^ pp[5][1];
        cor1[8]  = pp[0][7] | pp[1][6];
        cor1[9]  = pp[2][7] ^ pp[3][6];
        cor1[10] = pp[3][7];
        cor1[11] = pp[4][7] ^ pp[5][6];
        cor1[12] = pp[4][7] & pp[5][6];
    end

    always_comb begin
        cor2 = '0;
        cor2[7]  = pp[4][3] | pp[5][2];
        cor2[8]  = pp[1][7];
        cor2[9]  = pp[4][5] ^ pp[5][4];
        cor2[10] = pp[4][5] & pp[5][4];
        cor2[12] = pp[5][7];
    end

    always_comb begin
        cor3 = '0;
        cor3[8]  = pp[2][5] ^ pp[3][4];
        cor3[10] = pp[4][6] & pp[5][5];
    end

    always_comb begin
        cor4 = '0;
        cor4[8]  = pp[2][6] & pp[3][5];
        cor4[10] = pp[4][6] | pp[5][5];
    end

    // carries of the column 8 pairs
    always_comb begin
        cor5 = '0;
        cor5[8] = pp[2][6] | pp[3][5];
    end

    always_comb begin
        cor6 = '0;
        cor6[8] = pp[4][4] | pp[5][3];
    end

    // ########################################################################
    // final sum
    // ########################################################################

    // top two rows stay exact
    assign row6 = {2'b0, pp[6], 6'b0};
    assign row7 = {1'b0, pp[7], 7'b0};

    assign cor_sum = {3'b0, cor1} + {3'b0, cor2} + {3'b0, cor3}
                   + {3'b0, cor4} + {3'b0, cor5} + {3'b0, cor6};

    assign z = row6 + row7 + cor_sum;

endmodule

`default_nettype wire

/* lenet_weight_store.sv */
`default_nettype none

module lenet_weight_store
    import lenet_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 w_we,
    input  logic [W_ADDR_W-1:0]  w_addr,
    input  logic [PIX_W-1:0]     w_data,
    input  logic [ROW_IDX_W-1:0] row_idx,
    output wgt_row_t             row_wgt,
    output logic signed [PIX_W-1:0] bias
);

    logic [PIX_W-1:0] wgt_q [KERNEL*KERNEL];

    // kernel and bias registers
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < KERNEL*KERNEL; i++) begin
                wgt_q[i] <= '0;
            end
            bias <= '0;
        end else if (w_we) begin
            if (w_addr < BIAS_ADDR) begin
                wgt_q[w_addr] <= w_data;
            end else if (w_addr == BIAS_ADDR) begin
                bias <= w_data;
            end
        end
    end

    // row read, combinational
    always_comb begin
        logic [W_ADDR_W-1:0] base;

        base = W_ADDR_W'(row_idx) * W_ADDR_W'(KERNEL);
        for (int i = 0; i < KERNEL; i++) begin
            if (row_idx < ROW_IDX_W'(KERNEL)) begin
                row_wgt.wgt[i] = wgt_q[base + W_ADDR_W'(i)];
            end else begin
                row_wgt.wgt[i] = '0;
            end
        end
    end

endmodule

`default_nettype wire

/* lenet_row_dot.sv */
`default_nettype none

module lenet_row_dot
    import lenet_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 row_valid,
    input  pix_row_t             row_pix,
    input  wgt_row_t             row_wgt,
    output logic                 row_sum_valid,
    output logic [ROW_SUM_W-1:0] row_sum
);

    logic [PROD_W-1:0] prod [KERNEL];

    logic [PROD_W:0]      sum_a;
    logic [PROD_W:0]      sum_b;
    logic [PROD_W+1:0]    sum_ab;
    logic [ROW_SUM_W-1:0] sum_all;

    // ########################################################################
    // products, pixel on x and weight on y
    // ########################################################################

    for (genvar i = 0; i < KERNEL; i++) begin : g_mul
        lenet_approx_mul u_mul (
            .x (row_pix.pix[i]),
            .y (row_wgt.wgt[i]),
            .z (prod[i])
        );
    end

    // ########################################################################
    // adder tree
    // ########################################################################

    assign sum_a   = {1'b0, prod[0]} + {1'b0, prod[1]};
    assign sum_b   = {1'b0, prod[2]} + {1'b0, prod[3]};
    assign sum_ab  = {1'b0, sum_a} + {1'b0, sum_b};
    assign sum_all = {1'b0, sum_ab} + {3'b0, prod[4]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            row_sum_valid <= 1'b0;
        end else begin
            row_sum_valid <= row_valid;
        end
    end

    // sum only captured with a row
    always_ff @(posedge clk) begin
        if (row_valid) begin
            row_sum <= sum_all;
        end
    end

endmodule

`default_nettype wire

/* lenet_window_accum.sv */
`default_nettype none

module lenet_window_accum
    import lenet_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 row_valid,
    output logic [ROW_IDX_W-1:0] row_idx,
    input  logic                 row_sum_valid,
    input  logic [ROW_SUM_W-1:0] row_sum,
    output logic                 win_valid,
    output logic [ACC_W-1:0]     win_sum
);

    logic [ROW_IDX_W-1:0] in_cnt;
    logic [ROW_IDX_W-1:0] out_cnt;
    logic [ACC_W-1:0]     acc;
    logic [ACC_W-1:0]     acc_next;
    logic                 last_row;

    // ########################################################################
    // input side, selects the weight row
    // ########################################################################

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_cnt <= '0;
        end else if (row_valid) begin
            if (in_cnt == ROW_IDX_W'(KERNEL - 1)) begin
                in_cnt <= '0;
            end else begin
                in_cnt <= in_cnt + 1'b1;
            end
        end
    end

    assign row_idx = in_cnt;

    // ########################################################################
    // output side, sums arriving rows
    // ########################################################################

    assign acc_next = acc + ACC_W'(row_sum);
    assign last_row = (out_cnt == ROW_IDX_W'(KERNEL - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_cnt   <= '0;
            acc       <= '0;
            win_valid <= 1'b0;
        end else begin
            win_valid <= row_sum_valid & last_row;
            if (row_sum_valid) begin
                if (last_row) begin
                    // clear so the next window starts next cycle
                    out_cnt <= '0;
                    acc     <= '0;
                end else begin
                    out_cnt <= out_cnt + 1'b1;
                    acc     <= acc_next;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (row_sum_valid && last_row) begin
            win_sum <= acc_next;
        end
    end

endmodule

`default_nettype wire

/* lenet_requant.sv */
`default_nettype none

module lenet_requant
    import lenet_pkg::*;
(
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    win_valid,
    input  logic [ACC_W-1:0]        win_sum,
    input  logic signed [PIX_W-1:0] bias,
    output logic                    act_valid,
    output logic [PIX_W-1:0]        act_data
);

    logic signed [ACC_W+1:0]   sum_ext;
    logic signed [ACC_W+1:0]   bias_ext;
    logic signed [ACC_W+1:0]   pre;
    logic [ACC_W+1-ACT_SHIFT:0] scaled;
    logic [PIX_W-1:0]          act_next;

    // bias at activation scale
    assign sum_ext  = {2'b0, win_sum};
    assign bias_ext = {{(ACC_W+2-PIX_W-ACT_SHIFT){bias[PIX_W-1]}}, bias, {ACT_SHIFT{1'b0}}};
    assign pre      = sum_ext + bias_ext;

    assign scaled = pre[ACC_W+1:ACT_SHIFT];

    // relu, then saturate
    always_comb begin
        if (pre[ACC_W+1]) begin
            act_next = '0;
        end else if (|scaled[ACC_W+1-ACT_SHIFT:PIX_W]) begin
            act_next = '1;
        end else begin
            act_next = scaled[PIX_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            act_valid <= 1'b0;
        end else begin
            act_valid <= win_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (win_valid) begin
            act_data <= act_next;
        end
    end

endmodule

`default_nettype wire

/* lenet_conv_top.sv */
`default_nettype none

module lenet_conv_top
    import lenet_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  logic                w_we,
    input  logic [W_ADDR_W-1:0] w_addr,
    input  logic [PIX_W-1:0]    w_data,
    input  logic                row_valid,
    input  pix_row_t            row_pix,
    output logic                act_valid,
    output logic [PIX_W-1:0]    act_data
);

    logic [ROW_IDX_W-1:0]    row_idx;
    wgt_row_t                row_wgt;
    logic signed [PIX_W-1:0] bias;
    logic                    row_sum_valid;
    logic [ROW_SUM_W-1:0]    row_sum;
    logic                    win_valid;
    logic [ACC_W-1:0]        win_sum;

    lenet_weight_store u_store (
        .clk     (clk),
        .arst_n  (arst_n),
        .w_we    (w_we),
        .w_addr  (w_addr),
        .w_data  (w_data),
        .row_idx (row_idx),
        .row_wgt (row_wgt),
        .bias    (bias)
    );

    lenet_row_dot u_row_dot (
        .clk           (clk),
        .arst_n        (arst_n),
        .row_valid     (row_valid),
        .row_pix       (row_pix),
        .row_wgt       (row_wgt),
        .row_sum_valid (row_sum_valid),
        .row_sum       (row_sum)
    );

    lenet_window_accum u_accum (
        .clk           (clk),
        .arst_n        (arst_n),
        .row_valid     (row_valid),
        .row_idx       (row_idx),
        .row_sum_valid (row_sum_valid),
        .row_sum       (row_sum),
        .win_valid     (win_valid),
        .win_sum       (win_sum)
    );

    lenet_requant u_requant (
        .clk       (clk),
        .arst_n    (arst_n),
        .win_valid (win_valid),
        .win_sum   (win_sum),
        .bias      (bias),
        .act_valid (act_valid),
        .act_data  (act_data)
    );

endmodule

`default_nettype wire

/* tb_lenet_conv.sv */
`default_nettype none

module tb_lenet_conv
    import lenet_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int NUM_WIN    = 2 + 10 + 20 + 30 + 10 + 2 + 2 + 10;
    localparam int MARGIN     = 800;
    localparam int WATCHDOG   = (NUM_WIN * KERNEL * 3 + MARGIN) * CLK_PERIOD;

    typedef struct packed {
        int         due;
        logic [7:0] act;
    } expect_t;

    logic                clk;
    logic                arst_n;
    logic                w_we;
    logic [W_ADDR_W-1:0] w_addr;
    logic [PIX_W-1:0]    w_data;
    logic                row_valid;
    pix_row_t            row_pix;
    logic                act_valid;
    logic [PIX_W-1:0]    act_data;

    integer            seed;
    int                cyc;
    int                err_cnt;
    int                sent;
    int                checked;
    bit                exact_mode;
    expect_t           exp_q [$];
    logic [PIX_W-1:0]  wm [KERNEL*KERNEL];
    logic signed [7:0] bm;

    lenet_conv_top uut (
        .clk       (clk),
        .arst_n    (arst_n),
        .w_we      (w_we),
        .w_addr    (w_addr),
        .w_data    (w_data),
        .row_valid (row_valid),
        .row_pix   (row_pix),
        .act_valid (act_valid),
        .act_data  (act_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    // ########################################################################
    // reference model
    // ########################################################################

    // rows 6 and 7 exact, lower rows only through sparse bit terms
    function automatic int approx_product(input logic [7:0] x, input logic [7:0] y);
        logic [7:0][7:0] p;
        int z;
        for (int i = 0; i < 8; i++) begin
            p[i] = y & {8{x[i]}};
        end
        z = int'(p[6]) * 64 + int'(p[7]) * 128;
        z += int'(p[4][1] & p[5][0]) << 5;
        z += int'(p[2][4] ^ p[3][3]) << 6;
        z += (int'(p[4][2] ^ p[5][1]) + int'(p[4][3] | p[5][2])) << 7;
        z += (int'(p[0][7] | p[1][6]) + int'(p[1][7]) + int'(p[2][5] ^ p[3][4])
            + int'(p[2][6] & p[3][5]) + int'(p[2][6] | p[3][5])
            + int'(p[4][4] | p[5][3])) << 8;
        z += (int'(p[2][7] ^ p[3][6]) + int'(p[4][5] ^ p[5][4])) << 9;
        z += (int'(p[3][7]) + int'(p[4][5] & p[5][4]) + int'(p[4][6] & p[5][5])
            + int'(p[4][6] | p[5][5])) << 10;
        z += int'(p[4][7] ^ p[5][6]) << 11;
        z += (int'(p[4][7] & p[5][6]) + int'(p[5][7])) << 12;
        return z;
    endfunction

    function automatic logic [7:0] requant_model(input int win, input logic signed [7:0] b);
        int pre;
        pre = win + int'(b) * 256;
        if (pre < 0) begin
            return 8'd0;
        end
        pre = pre / 256;
        if (pre > 255) begin
            return 8'd255;
        end
        return pre[7:0];
    endfunction

    // ########################################################################
    // stimulus
    // ########################################################################

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            row_valid = 1'b0;
            w_we      = 1'b0;
        end
    endtask

    task automatic write_reg(input int addr, input logic [7:0] data);
        @(posedge clk);
        #2;
        row_valid = 1'b0;
        w_we      = 1'b1;
        w_addr    = addr[W_ADDR_W-1:0];
        w_data    = data;
        // addresses above the bias are ignored
        if (addr < KERNEL * KERNEL) begin
            wm[addr] = data;
        end else if (addr == int'(BIAS_ADDR)) begin
            bm = data;
        end
    endtask

    task automatic load_kernel(input logic [7:0] w_and, input logic [7:0] w_or,
                               input logic signed [7:0] b);
        logic [7:0] d;
        for (int a = 0; a < KERNEL * KERNEL; a++) begin
            d = ($random(seed) & w_and) | w_or;
            write_reg(a, d);
        end
        write_reg(int'(BIAS_ADDR), b);
        idle_cycles(1);
    endtask

    task automatic send_window(input int gap_max, input logic [7:0] pix_and,
                               input logic [7:0] pix_or);
        int         win;
        int         gap;
        logic [7:0] p;
        expect_t    e;
        win = 0;
        for (int r = 0; r < KERNEL; r++) begin
            @(posedge clk);
            #2;
            w_we      = 1'b0;
            row_valid = 1'b1;
            for (int i = 0; i < KERNEL; i++) begin
                p = ($random(seed) & pix_and) | pix_or;
                row_pix.pix[i] = p;
                if (exact_mode) begin
                    win += int'(p) * int'(wm[r*KERNEL+i]);
                end else begin
                    win += approx_product(p, wm[r*KERNEL+i]);
                end
            end
            if (r == KERNEL - 1) begin
                e.due = cyc + 3;
                e.act = requant_model(win, bm);
                exp_q.push_back(e);
                sent++;
            end
            if (gap_max > 0) begin
                gap = $unsigned($random(seed)) % (gap_max + 1);
                idle_cycles(gap);
            end
        end
    endtask

    task automatic drain;
        idle_cycles(1);
        while (exp_q.size() != 0) begin
            idle_cycles(1);
        end
        idle_cycles(2);
    endtask

    // ########################################################################
    // output monitor
    // ########################################################################

    always @(negedge clk) begin : monitor
        expect_t e;
        if (!arst_n) begin
            if (act_valid) begin
                err_cnt++;
                $display("act_valid went high during reset at %0t", $time);
            end
        end else if (act_valid) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("unexpected act_valid pulse at %0t", $time);
            end else begin
                e = exp_q.pop_front();
                checked++;
                if (e.due != cyc) begin
                    err_cnt++;
                    $display("act_valid at %0t came in cycle %0d, due in cycle %0d",
                             $time, cyc, e.due);
                end
                if (act_data !== e.act) begin
                    err_cnt++;
                    $display("CHECK FAILED at %0t: act_data expected %0d got %0d",
                             $time, e.act, act_data);
                end
            end
        end else if (exp_q.size() != 0 && exp_q[0].due <= cyc) begin
            err_cnt++;
            $display("missing act_valid pulse, due in cycle %0d, at %0t", exp_q[0].due, $time);
            void'(exp_q.pop_front());
        end
    end

    initial begin
        #(WATCHDOG);
        $display("watchdog expired at %0t with %0d windows outstanding", $time, exp_q.size());
        $display("Test failed");
        $finish;
    end

    // ########################################################################
    // test sequence
    // ########################################################################

    initial begin
        seed       = 32'h76f8;
        cyc        = 0;
        err_cnt    = 0;
        sent       = 0;
        checked    = 0;
        exact_mode = 1'b0;
        arst_n     = 1'b0;
        w_we       = 1'b0;
        w_addr     = '0;
        w_data     = '0;
        row_valid  = 1'b0;
        row_pix    = '0;
        bm         = '0;
        for (int a = 0; a < KERNEL * KERNEL; a++) begin
            wm[a] = '0;
        end
        repeat (10) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // zero kernel out of reset
        repeat (2) send_window(1, 8'hff, 8'h00);
        drain();

        // exact region, pixels with low six bits clear
        exact_mode = 1'b1;
        load_kernel(8'h3f, 8'h00, -8'sd100);
        repeat (10) send_window(2, 8'hc0, 8'h00);
        drain();
        exact_mode = 1'b0;

        // small weights keep most windows below saturation
        load_kernel(8'h1f, 8'h00, $random(seed));
        repeat (20) send_window(2, 8'hff, 8'h00);
        drain();

        // rows on every cycle
        repeat (30) send_window(0, 8'hff, 8'h00);
        drain();

        // full-range weights, small pixels
        load_kernel(8'hff, 8'h00, $random(seed));
        repeat (10) send_window(2, 8'h0f, 8'h00);
        drain();

        // relu, then saturation
        load_kernel(8'h0f, 8'h00, -8'sd100);
        repeat (2) send_window(0, 8'h03, 8'h00);
        drain();
        load_kernel(8'h00, 8'hff, 8'sd0);
        repeat (2) send_window(0, 8'h00, 8'hff);
        drain();

        // full reload, junk above the bias address
        for (int a = 0; a < 32; a++) begin
            write_reg(a, $random(seed));
        end
        idle_cycles(1);
        repeat (10) send_window(1, 8'h0f, 8'h00);
        drain();

        $display("errors: %0d, windows sent: %0d, windows checked: %0d",
                 err_cnt, sent, checked);
        if (err_cnt == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
lenet_pkg.sv
lenet_approx_mul.sv
lenet_weight_store.sv
lenet_row_dot.sv
lenet_window_accum.sv
lenet_requant.sv
lenet_conv_top.sv
tb_lenet_conv.sv
